// ==== hdl/issue_bus_pkg.sv ====
`default_nettype none

package issue_bus_pkg;

    import issue_pkg::*;

    // one queue entry, word plus the slot it came from
    typedef struct packed {
        inst_t     inst;
        slot_idx_t slot;
    } issue_entry_t;

    // slot 0 sits in the low word
    typedef struct packed {
        inst_t [N_SLOTS-1:0] inst;
        slot_idx_t           first_branch;
    } fetch_bundle_t;

    // compacted batch for one queue, valid entries from index 0 up
    typedef struct packed {
        issue_entry_t [N_SLOTS-1:0] entry;
        slot_cnt_t                  count;
    } entry_vec_t;

endpackage

`default_nettype wire

// ==== hdl/issue_classify.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_classify
    import issue_pkg::*, issue_bus_pkg::*;
(
    input  wire fetch_bundle_t i_bundle,
    output entry_vec_t         o_lsu,
    output entry_vec_t         o_csr,
    output entry_vec_t         o_alu
);

    logic [N_SLOTS-1:0] keep;
    logic [N_SLOTS-1:0] sel_lsu;
    logic [N_SLOTS-1:0] sel_csr;
    logic [N_SLOTS-1:0] sel_alu;

    function automatic iq_class_t class_of(input inst_t w);
        case (w[6:0])
            OPC_LOAD, OPC_STORE, OPC_AMO: class_of = LSU;
            OPC_SYSTEM:                   class_of = CSR;
            default:                      class_of = ALU;
        endcase
    endfunction

    // pack selected slots to the bottom, keeping slot order
    function automatic entry_vec_t pack_class(
        input fetch_bundle_t      b,
        input logic [N_SLOTS-1:0] sel
    );
        entry_vec_t v;
        v = '0;
        for (int s = 0; s < N_SLOTS; s++) begin
            if (sel[s]) begin
                v.entry[slot_idx_t'(v.count)].inst = b.inst[s];
                v.entry[slot_idx_t'(v.count)].slot = slot_idx_t'(s);
                v.count = v.count + 1'b1;
            end
        end
        return v;
    endfunction

    always_comb begin
        iq_class_t cls;
        for (int s = 0; s < N_SLOTS; s++) begin
            cls = class_of(i_bundle.inst[s]);
            // the branch slot itself is kept
            keep[s] = (slot_idx_t'(s) <= i_bundle.first_branch);
            sel_lsu[s] = keep[s] && (cls == LSU);
            sel_csr[s] = keep[s] && (cls == CSR);
            sel_alu[s] = keep[s] && (cls == ALU);
        end
    end

    assign o_lsu = pack_class(i_bundle, sel_lsu);
    assign o_csr = pack_class(i_bundle, sel_csr);
    assign o_alu = pack_class(i_bundle, sel_alu);

endmodule

`default_nettype wire

// ==== hdl/issue_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_dispatch
    import issue_pkg::*, issue_bus_pkg::*;
(
    input  wire                i_w_fire00_1,
    input  wire                rstn,
    input  wire                i_drive,
    input  wire fetch_bundle_t i_bundle,
    output logic               o_free,
    output fetch_bundle_t      o_bundle,
    input  wire slot_cnt_t     i_lsu_cnt,
    input  wire slot_cnt_t     i_csr_cnt,
    input  wire slot_cnt_t     i_alu_cnt,
    input  wire q_level_t      i_lsu_level,
    input  wire q_level_t      i_csr_level,
    input  wire q_level_t      i_alu_level,
    output logic               o_wr_en
);

    fetch_bundle_t bundle_q;
    logic          full;
    logic          room;
    logic          accept;

    function automatic logic has_room(input q_level_t level, input slot_cnt_t cnt);
        return (q_level_t'(Q_DEPTH) - level) >= q_level_t'(cnt);
    endfunction

    assign o_free   = !full;
    assign accept   = i_drive && o_free;
    assign o_bundle = bundle_q;

    // all three must fit, no partial release
    assign room = has_room(i_lsu_level, i_lsu_cnt)
               && has_room(i_csr_level, i_csr_cnt)
               && has_room(i_alu_level, i_alu_cnt);
    assign o_wr_en = full && room;

    always_ff @(posedge i_w_fire00_1) begin
        if (accept) begin
            bundle_q <= i_bundle;
        end
    end

    always_ff @(posedge i_w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (o_wr_en) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end
    end

    // each held bundle goes to the queues exactly once
    a_wr_once: assert property (@(posedge i_w_fire00_1) disable iff (!rstn)
        o_wr_en |-> $past(accept) || ($past(full) && !$past(o_wr_en)));

endmodule

`default_nettype wire

// ==== hdl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    localparam int N_SLOTS = 8;
    localparam int Q_DEPTH = 16;

    // riscv major opcodes that leave the alu path
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_AMO    = 7'b0101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef logic [31:0] inst_t;
    typedef logic [2:0]  slot_idx_t;
    // 0 to N_SLOTS
    typedef logic [3:0]  slot_cnt_t;
    // 0 to Q_DEPTH
    typedef logic [4:0]  q_level_t;
    typedef logic [$clog2(Q_DEPTH)-1:0] q_ptr_t;

    typedef enum logic [1:0] {
        ALU,
        LSU,
        CSR
    } iq_class_t;

endpackage

`default_nettype wire

// ==== hdl/issue_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_queue
    import issue_pkg::*, issue_bus_pkg::*;
(
    input  wire             i_w_fire00_1,
    input  wire             rstn,
    input  wire             i_wr_en,
    input  wire entry_vec_t i_batch,
    output q_level_t        o_level,
    output logic            o_drive,
    output issue_entry_t    o_entry,
    input  wire             i_free
);

    issue_entry_t mem [Q_DEPTH];
    q_ptr_t       wr_ptr;
    q_ptr_t       rd_ptr;
    q_level_t     level;
    q_level_t     level_nxt;
    logic         pop;

    // head is valid whenever anything is stored
    assign o_drive = (level != '0);
    assign o_entry = mem[rd_ptr];
    assign o_level = level;
    assign pop     = o_drive && i_free;

    always_comb begin
        level_nxt = level;
        if (i_wr_en) begin
            level_nxt = level_nxt + q_level_t'(i_batch.count);
        end
        if (pop) begin
            level_nxt = level_nxt - 1'b1;
        end
    end

    // batch lands at consecutive slots from wr_ptr, wrapping
    always_ff @(posedge i_w_fire00_1) begin
        if (i_wr_en) begin
            for (int k = 0; k < N_SLOTS; k++) begin
                if (slot_cnt_t'(k) < i_batch.count) begin
                    mem[wr_ptr + q_ptr_t'(k)] <= i_batch.entry[k];
                end
            end
        end
    end

    always_ff @(posedge i_w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= wr_ptr + q_ptr_t'(i_batch.count);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level_nxt;
        end
    end

    // room is judged upstream in the dispatch
    a_no_overflow: assert property (@(posedge i_w_fire00_1) disable iff (!rstn)
        i_wr_en |-> int'(level) + int'(i_batch.count) <= Q_DEPTH);

    a_head_hold: assert property (@(posedge i_w_fire00_1) disable iff (!rstn)
        o_drive && !i_free |=> o_drive && $stable(o_entry));

endmodule

`default_nettype wire

// ==== hdl/issue_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_top
    import issue_pkg::*, issue_bus_pkg::*;
(
    input  wire                i_w_fire00_1,
    input  wire                rstn,
    input  wire                i_drive,
    input  wire fetch_bundle_t i_bundle,
    output logic               o_free,
    output logic               o_lsu_drive,
    output issue_entry_t       o_lsu_entry,
    input  wire                i_lsu_free,
    output logic               o_csr_drive,
    output issue_entry_t       o_csr_entry,
    input  wire                i_csr_free,
    output logic               o_alu_drive,
    output issue_entry_t       o_alu_entry,
    input  wire                i_alu_free
);

    fetch_bundle_t bundle;
    entry_vec_t    lsu_batch;
    entry_vec_t    csr_batch;
    entry_vec_t    alu_batch;
    q_level_t      lsu_level;
    q_level_t      csr_level;
    q_level_t      alu_level;
    logic          wr_en;

    issue_dispatch issue_dispatch_i (
        .i_w_fire00_1 (i_w_fire00_1),
        .rstn         (rstn),
        .i_drive      (i_drive),
        .i_bundle     (i_bundle),
        .o_free       (o_free),
        .o_bundle     (bundle),
        .i_lsu_cnt    (lsu_batch.count),
        .i_csr_cnt    (csr_batch.count),
        .i_alu_cnt    (alu_batch.count),
        .i_lsu_level  (lsu_level),
        .i_csr_level  (csr_level),
        .i_alu_level  (alu_level),
        .o_wr_en      (wr_en)
    );

    issue_classify issue_classify_i (
        .i_bundle (bundle),
        .o_lsu    (lsu_batch),
        .o_csr    (csr_batch),
        .o_alu    (alu_batch)
    );

    // one shared write strobe, each queue takes its own batch
    issue_queue lsu_queue_i (
        .i_w_fire00_1 (i_w_fire00_1),
        .rstn         (rstn),
        .i_wr_en      (wr_en),
        .i_batch      (lsu_batch),
        .o_level      (lsu_level),
        .o_drive      (o_lsu_drive),
        .o_entry      (o_lsu_entry),
        .i_free       (i_lsu_free)
    );

    issue_queue csr_queue_i (
        .i_w_fire00_1 (i_w_fire00_1),
        .rstn         (rstn),
        .i_wr_en      (wr_en),
        .i_batch      (csr_batch),
        .o_level      (csr_level),
        .o_drive      (o_csr_drive),
        .o_entry      (o_csr_entry),
        .i_free       (i_csr_free)
    );

    issue_queue alu_queue_i (
        .i_w_fire00_1 (i_w_fire00_1),
        .rstn         (rstn),
        .i_wr_en      (wr_en),
        .i_batch      (alu_batch),
        .o_level      (alu_level),
        .o_drive      (o_alu_drive),
        .o_entry      (o_alu_entry),
        .i_free       (i_alu_free)
    );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verif
hdl/issue_pkg.sv
hdl/issue_bus_pkg.sv
hdl/issue_classify.sv
hdl/issue_queue.sv
hdl/issue_dispatch.sv
hdl/issue_top.sv
verif/issue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then judge the run by its log
rm -rf obj_dir run.log
verilator --binary --timing --assert -f list.f --top-module issue_tb -o issue_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/issue_sim > run.log 2>&1 || true
cat run.log
grep -q "TEST RESULT: FAIL" run.log && exit 1
grep -q "TEST RESULT: PASS" run.log || exit 1
exit 0

// ==== verif/issue_tb_table.svh ====
`ifndef ISSUE_TB_TABLE_SVH
`define ISSUE_TB_TABLE_SVH

// columns: major opcode per slot with slot 7 on the left, then first_branch
// upper 25 bits of every word come from the lfsr when the bundle is built

localparam logic [6:0] OP_LD  = OPC_LOAD;
localparam logic [6:0] OP_ST  = OPC_STORE;
localparam logic [6:0] OP_AMO = OPC_AMO;
localparam logic [6:0] OP_SYS = OPC_SYSTEM;
localparam logic [6:0] OP_OPI = 7'b0010011;
localparam logic [6:0] OP_OP  = 7'b0110011;
localparam logic [6:0] OP_BR  = 7'b1100011;
localparam logic [6:0] OP_LUI = 7'b0110111;
localparam int N_BUNDLES = 12;

typedef struct packed {
    logic [N_SLOTS-1:0][6:0] opc;
    slot_idx_t               first_branch;
} table_row_t;

table_row_t bundle_table [N_BUNDLES] = '{
    '{{OP_BR,  OP_SYS, OP_ST,  OP_OP,  OP_LD,  OP_OPI, OP_AMO, OP_LUI}, 3'd7},
    '{{OP_LD,  OP_LD,  OP_SYS, OP_ST,  OP_BR,  OP_OPI, OP_SYS, OP_LD }, 3'd3},
    '{{OP_SYS, OP_LD,  OP_ST,  OP_AMO, OP_SYS, OP_OP,  OP_LD,  OP_BR }, 3'd0},
    '{{OP_BR,  OP_OP,  OP_OPI, OP_LUI, OP_OP,  OP_OPI, OP_OP,  OP_OPI}, 3'd7},
    '{{OP_LD,  OP_ST,  OP_AMO, OP_LD,  OP_ST,  OP_LD,  OP_LD,  OP_ST }, 3'd7},
    '{{OP_ST,  OP_LD,  OP_LD,  OP_AMO, OP_LD,  OP_ST,  OP_LD,  OP_LD }, 3'd7},
    '{{OP_LD,  OP_LD,  OP_ST,  OP_ST,  OP_LD,  OP_AMO, OP_LD,  OP_ST }, 3'd7},
    '{{OP_LD,  OP_OP,  OP_BR,  OP_LD,  OP_SYS, OP_LD,  OP_OPI, OP_ST }, 3'd5},
    '{{OP_SYS, OP_SYS, OP_SYS, OP_SYS, OP_SYS, OP_SYS, OP_SYS, OP_SYS}, 3'd7},
    '{{OP_LD,  OP_SYS, OP_OP,  OP_ST,  OP_LD,  OP_BR,  OP_SYS, OP_AMO}, 3'd2},
    '{{OP_SYS, OP_BR,  OP_LD,  OP_OP,  OP_SYS, OP_OPI, OP_ST,  OP_LUI}, 3'd6},
    '{{OP_BR,  OP_LD,  OP_OPI, OP_SYS, OP_ST,  OP_LUI, OP_AMO, OP_OP }, 3'd7}
};

// output for an opcode: 0 lsu, 1 csr, 2 alu
function automatic int queue_for_opcode(input logic [6:0] opc);
    if (opc == OP_LD || opc == OP_ST || opc == OP_AMO) begin
        return 0;
    end
    if (opc == OP_SYS) begin
        return 1;
    end
    return 2;
endfunction

`endif

// ==== verif/issue_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_tb
    import issue_pkg::*, issue_bus_pkg::*;
();

    `include "issue_tb_table.svh"

    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int STALL_BUNDLE = 4;
    localparam int STALL_CYCLES = 40;
    localparam int CYCLE_LIMIT  = 40 * N_BUNDLES + 200;

    logic          w_fire00_1;
    logic          rstn;
    logic          i_drive;
    fetch_bundle_t i_bundle;
    logic          o_free;
    logic          o_lsu_drive;
    issue_entry_t  o_lsu_entry;
    logic          i_lsu_free;
    logic          o_csr_drive;
    issue_entry_t  o_csr_entry;
    logic          i_csr_free;
    logic          o_alu_drive;
    issue_entry_t  o_alu_entry;
    logic          i_alu_free;

    logic [31:0]  lfsr_state = 32'hd74b711c;
    issue_entry_t exp_lsu [$];
    issue_entry_t exp_csr [$];
    issue_entry_t exp_alu [$];
    int           cycles = 0;
    int           stall_left = 0;
    logic         free_seen = 1'b0;
    logic         saw_free_low = 1'b0;
    logic         free_back = 1'b0;

    issue_top issue_top_i (
        .i_w_fire00_1 (w_fire00_1),
        .rstn         (rstn),
        .i_drive      (i_drive),
        .i_bundle     (i_bundle),
        .o_free       (o_free),
        .o_lsu_drive  (o_lsu_drive),
        .o_lsu_entry  (o_lsu_entry),
        .i_lsu_free   (i_lsu_free),
        .o_csr_drive  (o_csr_drive),
        .o_csr_entry  (o_csr_entry),
        .i_csr_free   (i_csr_free),
        .o_alu_drive  (o_alu_drive),
        .o_alu_entry  (o_alu_entry),
        .i_alu_free   (i_alu_free)
    );

    initial begin
        w_fire00_1 = 1'b0;
        forever #5 w_fire00_1 = ~w_fire00_1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_entry(input string name, input issue_entry_t got,
                               input issue_entry_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_drive(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // galois form, one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
    endtask

    // each free is high three cycles in four on average
    task automatic update_frees();
        logic [31:0] r;
        take_bits(6, r);
        i_lsu_free = |r[1:0];
        i_csr_free = |r[3:2];
        i_alu_free = |r[5:4];
        if (stall_left > 0) begin
            i_lsu_free = 1'b0;
            stall_left--;
        end
    endtask

    task automatic next_cycle();
        @(negedge w_fire00_1);
        free_seen = o_free;
        if (stall_left > 0 && !o_free) begin
            saw_free_low = 1'b1;
        end
        if (saw_free_low && stall_left == 0 && o_free) begin
            free_back = 1'b1;
        end
        @(posedge w_fire00_1);
        #1;
        update_frees();
    endtask

    // kept slots go to their output in rising slot order
    task automatic expect_bundle(input table_row_t row, input fetch_bundle_t b);
        issue_entry_t e;
        for (int s = 0; s < N_SLOTS; s++) begin
            if (s <= int'(row.first_branch)) begin
                e.inst = b.inst[s];
                e.slot = slot_idx_t'(s);
                case (queue_for_opcode(row.opc[s]))
                    0: exp_lsu.push_back(e);
                    1: exp_csr.push_back(e);
                    default: exp_alu.push_back(e);
                endcase
            end
        end
    endtask

    task automatic pop_and_check(input string name, input int which, input issue_entry_t got);
        issue_entry_t exp;
        int left;
        case (which)
            0: left = exp_lsu.size();
            1: left = exp_csr.size();
            default: left = exp_alu.size();
        endcase
        if (left == 0) begin
            fail_run($sformatf("entry %h on %s came out but none was expected", got, name));
        end
        case (which)
            0: exp = exp_lsu.pop_front();
            1: exp = exp_csr.pop_front();
            default: exp = exp_alu.pop_front();
        endcase
        check_entry(name, got, exp);
    endtask

    // values seen at the falling edge are the ones the next rising edge transfers
    always @(negedge w_fire00_1) begin
        if (rstn) begin
            if (o_lsu_drive && i_lsu_free) begin
                pop_and_check("o_lsu_entry", 0, o_lsu_entry);
            end
            if (o_csr_drive && i_csr_free) begin
                pop_and_check("o_csr_entry", 1, o_csr_entry);
            end
            if (o_alu_drive && i_alu_free) begin
                pop_and_check("o_alu_entry", 2, o_alu_entry);
            end
        end
    end

    always @(posedge w_fire00_1) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        fetch_bundle_t bundle;
        table_row_t    row;
        logic [31:0]   r;
        rstn       = 1'b0;
        i_drive    = 1'b0;
        i_bundle   = '0;
        i_lsu_free = 1'b0;
        i_csr_free = 1'b0;
        i_alu_free = 1'b0;
        repeat (4) @(posedge w_fire00_1);
        #1;
        rstn = 1'b1;
        @(negedge w_fire00_1);
        check_drive("o_lsu_drive", o_lsu_drive, 1'b0);
        check_drive("o_csr_drive", o_csr_drive, 1'b0);
        check_drive("o_alu_drive", o_alu_drive, 1'b0);
        check_drive("o_free", o_free, 1'b1);
        next_cycle();

        for (int b = 0; b < N_BUNDLES; b++) begin
            row = bundle_table[b];
            for (int s = 0; s < N_SLOTS; s++) begin
                take_bits(25, r);
                bundle.inst[s] = {r[24:0], row.opc[s]};
            end
            bundle.first_branch = row.first_branch;
            if (b == STALL_BUNDLE) begin
                stall_left = STALL_CYCLES;
            end
            i_bundle = bundle;
            i_drive  = 1'b1;
            do begin
                next_cycle();
            end while (!free_seen);
            expect_bundle(row, bundle);
        end
        i_drive = 1'b0;

        while (exp_lsu.size() + exp_csr.size() + exp_alu.size() != 0) begin
            next_cycle();
        end
        next_cycle();
        next_cycle();
        @(negedge w_fire00_1);
        check_drive("o_lsu_drive", o_lsu_drive, 1'b0);
        check_drive("o_csr_drive", o_csr_drive, 1'b0);
        check_drive("o_alu_drive", o_alu_drive, 1'b0);
        check_drive("o_free", o_free, 1'b1);

        if (!saw_free_low) begin
            fail_run("o_free never went low while the lsu output was stalled");
        end else if (!free_back) begin
            fail_run("o_free did not return high after the lsu stall ended");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
